/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  rv_ctrl_if.exe ctrl,
  input  word_t  pc,
  input  word_t  rs1_data,
  input  word_t  rs2_data,
  output word_t  result,
  output logic   take_jump,
  output word_t  jump_target
);

  word_t      a;
  word_t      b;
  logic [4:0] shamt;

  // Branch compare results
  logic br_eq;
  logic br_lt;
  logic br_ltu;
  logic br_cond;

  // ---------------------------------------------------------------------------
  // Operand selection
  // ---------------------------------------------------------------------------
  always_comb begin
    case (ctrl.alu_a_src)
      A_RS1:   a = rs1_data;
      A_ZERO:  a = '0;
      A_PC:    a = pc;
      default: a = rs1_data;
    endcase
  end

  assign b     = (ctrl.alu_b_src == B_IMM) ? ctrl.imm : rs2_data;
  // Shift amount from the low five bits only
  assign shamt = b[4:0];

  // ---------------------------------------------------------------------------
  // ALU
  // ---------------------------------------------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Branch condition
  // ---------------------------------------------------------------------------
  // Compares always use the register values
  assign br_eq  = (rs1_data == rs2_data);
  assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign br_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  br_cond = br_eq;
      F3_BNE:  br_cond = !br_eq;
      F3_BLT:  br_cond = br_lt;
      F3_BGE:  br_cond = !br_lt;
      F3_BLTU: br_cond = br_ltu;
      F3_BGEU: br_cond = !br_ltu;
      // Reserved encodings never branch
      default: br_cond = 1'b0;
    endcase
  end

  // Jumps always redirect, branches only on a true condition
  assign take_jump = ctrl.is_jump || (ctrl.is_branch && br_cond);

  // JALR target has bit 0 cleared, the rest are PC-relative
  assign jump_target = ctrl.is_jalr ? {result[XLEN-1:1], 1'b0} : pc + ctrl.imm;

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  // Instruction memory, read only
  output word_t imem_raddr,
  input  word_t imem_rdata,
  // Data memory read
  output logic  dmem_ren,
  output word_t dmem_raddr,
  input  word_t dmem_rdata,
  // Data memory write
  output logic  dmem_we,
  output word_t dmem_waddr,
  output word_t dmem_wdata,
  output strb_t dmem_wstrb,
  output logic  ebreak
);

  word_t pc;
  word_t pc_plus4;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  word_t jump_target;
  word_t load_data;
  word_t rd_data;
  logic  take_jump;
  logic  halt;

  rv_ctrl_if ctrl ();

  // ---------------------------------------------------------------------------
  // Fetch and decode
  // ---------------------------------------------------------------------------
  assign imem_raddr = pc;
  // Ebreak stops the PC
  assign halt       = (imem_rdata == I_EBREAK);

  rv_pc #(.RESET_PC(RESET_PC)) u_pc (.clk(clk), .rst_n(rst_n), .take_jump(take_jump),
    .jump_target(jump_target), .halt(halt), .pc(pc), .pc_plus4(pc_plus4));

  rv_idec u_idec (.instr(imem_rdata), .ctrl(ctrl));

  rv_regfile u_regfile (.clk(clk), .rst_n(rst_n), .rs1(ctrl.rs1), .rs2(ctrl.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rd_en(ctrl.reg_write), .rd(ctrl.rd),
    .rd_data(rd_data));

  // ---------------------------------------------------------------------------
  // Execute and memory
  // ---------------------------------------------------------------------------
  rv_alu u_alu (.ctrl(ctrl), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .result(alu_result), .take_jump(take_jump), .jump_target(jump_target));

  rv_lsu u_lsu (.ctrl(ctrl), .addr(alu_result), .store_data(rs2_data),
    .dmem_rdata(dmem_rdata), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .load_data(load_data));

  // Same address for both ports
  assign dmem_raddr = alu_result;
  assign dmem_waddr = alu_result;
  // Strobes held low through reset
  assign dmem_ren   = rst_n && ctrl.mem_read;
  assign dmem_we    = rst_n && ctrl.mem_write;
  assign ebreak     = rst_n && halt;

  // Write-back select
  always_comb begin
    case (ctrl.res_src)
      RES_ALU: rd_data = alu_result;
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

/* rv_ctrl_if.sv */
`timescale 1ns/1ps

// Decoded control for the instruction in flight
interface rv_ctrl_if
  import rv_pkg::*;
();

  // Write enables
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  // Execute setup
  alu_op_e    alu_op;
  alu_a_src_e alu_a_src;
  alu_b_src_e alu_b_src;
  res_src_e   res_src;
  // Control flow
  logic       is_branch;
  logic       is_jump;
  logic       is_jalr;
  // Raw instruction fields
  funct3_t    funct3;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm;

  // Decoder side
  modport dec(output reg_write, mem_read, mem_write, alu_op, alu_a_src, alu_b_src,
              res_src, is_branch, is_jump, is_jalr, funct3, rd, rs1, rs2, imm);
  // Consumer side
  modport exe(input reg_write, mem_read, mem_write, alu_op, alu_a_src, alu_b_src,
              res_src, is_branch, is_jump, is_jalr, funct3, rd, rs1, rs2, imm);

endinterface

/* rv_idec.sv */
`timescale 1ns/1ps

module rv_idec
  import rv_pkg::*;
(
  input word_t   instr,
  rv_ctrl_if.dec ctrl
);

  logic [6:0] opcode;
  funct3_t    funct3;
  logic       funct7_b5;

  // Immediates of each format, sign-extended from bit 31
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // ALU operation from funct3, alt marks funct7 bit 5
  // Only register ops use alt to pick SUB over ADD
  function automatic alu_op_e alu_dec(input funct3_t f3, input logic alt,
                                      input logic reg_op);
    case (f3)
      F3_ADD:  return (alt && reg_op) ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  // ---------------------------------------------------------------------------
  // Field extraction
  // ---------------------------------------------------------------------------
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  assign ctrl.rd     = instr[11:7];
  assign ctrl.rs1    = instr[19:15];
  assign ctrl.rs2    = instr[24:20];
  assign ctrl.funct3 = funct3;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // ---------------------------------------------------------------------------
  // Control decode
  // ---------------------------------------------------------------------------
  always_comb begin
    // Defaults give a nop with no side effects
    ctrl.reg_write = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.alu_a_src = A_RS1;
    ctrl.alu_b_src = B_RS2;
    ctrl.res_src   = RES_ALU;
    ctrl.is_branch = 1'b0;
    ctrl.is_jump   = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.imm       = '0;

    case (opcode)
      OPC_LUI: begin
        // 0 + imm
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = A_ZERO;
        ctrl.alu_b_src = B_IMM;
        ctrl.imm       = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = A_PC;
        ctrl.alu_b_src = B_IMM;
        ctrl.imm       = imm_u;
      end
      OPC_JAL: begin
        // Link value is pc + 4, target from the PC-relative adder
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jump   = 1'b1;
        ctrl.imm       = imm_j;
      end
      OPC_JALR: begin
        // ALU forms rs1 + imm for the target
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_src = B_IMM;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jump   = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.imm       = imm_i;
      end
      OPC_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_b_src = B_IMM;
        ctrl.res_src   = RES_MEM;
        ctrl.imm       = imm_i;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_src = B_IMM;
        ctrl.imm       = imm_s;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_src = B_IMM;
        ctrl.alu_op    = alu_dec(funct3, funct7_b5, 1'b0);
        ctrl.imm       = imm_i;
      end
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_dec(funct3, funct7_b5, 1'b1);
      end
      OPC_SYSTEM: begin
        // Ebreak is caught in the core, nothing to write here
        ctrl.reg_write = 1'b0;
      end
      default: begin
        // Unknown opcode, keep the nop defaults
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu
  import rv_pkg::*;
(
  rv_ctrl_if.exe ctrl,
  input  word_t  addr,
  input  word_t  store_data,
  input  word_t  dmem_rdata,
  output word_t  dmem_wdata,
  output strb_t  dmem_wstrb,
  output word_t  load_data
);

  // Byte lane within the word
  logic [1:0]  lane;
  // Read word moved down to the addressed byte
  word_t       rd_shifted;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign lane = addr[1:0];

  // ---------------------------------------------------------------------------
  // Store formatting
  // ---------------------------------------------------------------------------
  always_comb begin
    dmem_wdata = store_data;
    dmem_wstrb = '0;
    case (ctrl.funct3)
      F3_SB: begin
        dmem_wdata = word_t'(store_data[7:0]) << {lane, 3'b000};
        dmem_wstrb = strb_t'(4'b0001 << lane);
      end
      F3_SH: begin
        // Upper or lower half by address bit 1
        dmem_wdata = word_t'(store_data[15:0]) << {lane[1], 4'b0000};
        dmem_wstrb = lane[1] ? 4'b1100 : 4'b0011;
      end
      F3_SW: begin
        dmem_wstrb = 4'b1111;
      end
      default: begin
        dmem_wstrb = '0;
      end
    endcase
    // No strobes unless this is a store
    if (!ctrl.mem_write) begin
      dmem_wstrb = '0;
    end
  end

  // ---------------------------------------------------------------------------
  // Load formatting
  // ---------------------------------------------------------------------------
  assign rd_shifted = dmem_rdata >> {lane, 3'b000};
  assign ld_byte    = rd_shifted[7:0];
  assign ld_half    = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      F3_LB:   load_data = {{24{ld_byte[7]}}, ld_byte};
      F3_LH:   load_data = {{16{ld_half[15]}}, ld_half};
      F3_LW:   load_data = dmem_rdata;
      F3_LBU:  load_data = {24'h000000, ld_byte};
      F3_LHU:  load_data = {16'h0000, ld_half};
      // Reserved sizes pass the word through
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

/* rv_pc.sv */
`timescale 1ns/1ps

module rv_pc
  import rv_pkg::*;
#(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  take_jump,
  input  word_t jump_target,
  input  logic  halt,
  output word_t pc,
  output word_t pc_plus4
);

  // Sequential successor, also the link value
  assign pc_plus4 = pc + word_t'(4);

  // Next PC
  // Halt freezes the PC so the core stays on ebreak
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (halt) begin
      pc <= pc;
    end else if (take_jump) begin
      pc <= jump_target;
    end else begin
      pc <= pc_plus4;
    end
  end

endmodule

/* rv_pkg.sv */
package rv_pkg;

  // Data path width, fixed for RV32I
  localparam int XLEN = 32;

  // Register values, addresses and instruction words
  typedef logic [XLEN-1:0] word_t;
  // Register index
  typedef logic [4:0] reg_idx_t;
  // Function field, selects branch condition and load/store size
  typedef logic [2:0] funct3_t;
  // Byte write strobe, one bit per lane
  typedef logic [3:0] strb_t;

  // ---------------------------------------------------------------------------
  // Opcodes
  // ---------------------------------------------------------------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Fixed encodings
  localparam word_t I_EBREAK = 32'h0010_0073;
  localparam word_t I_NOP    = 32'h0000_0013;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Load and store sizes, bit 2 marks unsigned loads
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;
  localparam funct3_t F3_SB  = 3'b000;
  localparam funct3_t F3_SH  = 3'b001;
  localparam funct3_t F3_SW  = 3'b010;

  // Integer operations, OP and OP_IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // ---------------------------------------------------------------------------
  // Control encodings
  // ---------------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {A_RS1 = 2'd0, A_ZERO = 2'd1, A_PC = 2'd2} alu_a_src_e;
  typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} alu_b_src_e;
  // Write-back source
  typedef enum logic [1:0] {RES_ALU = 2'd0, RES_MEM = 2'd1, RES_PC4 = 2'd2} res_src_e;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     rd_en,
  input  reg_idx_t rd,
  input  word_t    rd_data
);

  // x1..x31, x0 has no storage
  word_t regs[1:31];

  // Write on the edge that ends the instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Asynchronous reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          WAIT_LIMIT  = 50;
  localparam logic [31:0] STORE_BASE  = 32'h0000_0200;
  localparam logic [31:0] MARKER      = 32'h5A5A_0F0F;
  localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic        dmem_ren;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        ebreak;

  // Memory models of 1 KB each
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  // Untouched copy of the seeded data
  logic [31:0] dmem_init [0:255];

  // Program table and expected stores in program order
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_strb [$];
  // Expected load addresses in program order
  logic [31:0] exp_load [$];

  integer seed;
  int     errors;
  // Next free word slot above STORE_BASE
  int     slot;

  rv_core #(.RESET_PC(32'h0000_0000)) UUT (.clk(clk), .rst_n(rst_n),
    .imem_raddr(imem_raddr), .imem_rdata(imem_rdata), .dmem_ren(dmem_ren),
    .dmem_raddr(dmem_raddr), .dmem_rdata(dmem_rdata), .dmem_we(dmem_we),
    .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .ebreak(ebreak));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Zero-wait reads
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  // Byte-strobed write on the closing edge
  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      for (int l = 0; l < 4; l++) begin
        if (dmem_wstrb[l]) begin
          dmem[dmem_waddr[9:2]][8*l +: 8] <= dmem_wdata[8*l +: 8];
        end
      end
    end
  end

  // Every read strobe must match the next expected load
  always @(negedge clk) begin
    if (dmem_ren === 1'b1) begin
      if (exp_load.size() == 0) begin
        $display("Unexpected load from address %h", dmem_raddr);
        errors++;
      end else begin
        check_value("dmem_raddr", dmem_raddr, exp_load.pop_front());
      end
    end
  end

  // --------------------------------------------------------------------------
  // Instruction encoders for the RV32I formats
  // --------------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // --------------------------------------------------------------------------
  // Expected values by the ISA rules
  // --------------------------------------------------------------------------
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] sra_val;
    sra_val = $signed(a) >>> b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        // Arithmetic right shift when alt is set
        if (alt) begin
          return sra_val;
        end
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_expect(input logic [2:0] f3, input logic [31:0] w,
                                              input logic [1:0] off);
    logic [7:0]  b8;
    logic [15:0] h16;
    b8  = w >> (8 * off);
    h16 = w >> (8 * off);
    case (f3)
      3'd0:    return {{24{b8[7]}}, b8};
      3'd4:    return {24'h0, b8};
      3'd1:    return {{16{h16[15]}}, h16};
      3'd5:    return {16'h0, h16};
      default: return w;
    endcase
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return !($signed(a) < $signed(b));
      3'd6:    return a < b;
      default: return !(a < b);
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Program table builders
  // --------------------------------------------------------------------------
  task automatic put_instr(input logic [31:0] insn);
    prog.push_back(insn);
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_strb.push_back(strb);
  endtask

  // lui + addi with the upper part rounded for the signed low part
  task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] upper;
    upper = (val + 32'h800) >> 12;
    put_instr(enc_u(upper[19:0], rd, 7'b0110111));
    put_instr(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  task automatic store_check(input logic [4:0] rs, input logic [31:0] val);
    put_instr(enc_s(12'(slot * 4), rs, 5'd31, 3'b010));
    expect_store(STORE_BASE + 32'(slot * 4), val, 4'hF);
    slot++;
  endtask

  // Marker on the fall-through path is expected only if not skipped
  task automatic marker_store(input logic skipped);
    put_instr(enc_s(12'(slot * 4), 5'd5, 5'd31, 3'b010));
    if (!skipped) begin
      expect_store(STORE_BASE + 32'(slot * 4), MARKER, 4'hF);
    end
    slot++;
  endtask

  task automatic load_check(input logic [2:0] f3, input logic [11:0] addr);
    put_instr(enc_i(addr, 5'd0, f3, 5'd3, 7'b0000011));
    exp_load.push_back(32'(addr));
    store_check(5'd3, load_expect(f3, dmem_init[addr[9:2]], addr[1:0]));
  endtask

  task automatic build_program();
    logic [31:0] op_a [2]  = '{32'hF0F0_1234, 32'h1234_5678};
    logic [31:0] op_b [2]  = '{32'h0000_0013, 32'hFFFF_FF85};
    // {alt, funct3} of the ten register ops
    logic [3:0]  r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'h6, 4'h7};
    logic [2:0]  i_f3 [9]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    logic [11:0] i_imm [9] = '{12'hFF9, 12'h005, 12'hFFF, 12'h555, 12'hF00, 12'h0F0,
                               12'h007, 12'h009, 12'h409};
    logic [31:0] br_a [3]  = '{32'd5, 32'hFFFF_FFFD, 32'd5};
    logic [31:0] br_b [3]  = '{32'd5, 32'd5, 32'hFFFF_FFFD};
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0] pc_at;
    slot = 0;
    // A store at the reset PC tests the strobe gating in reset
    put_instr(enc_s(12'd0, 5'd0, 5'd0, 3'b010));
    expect_store(32'h0, 32'h0, 4'hF);
    load_imm(5'd31, STORE_BASE);
    load_imm(5'd5, MARKER);
    // Write to x0 must not stick
    put_instr(enc_i(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
    store_check(5'd0, 32'h0);
    // Register-register ops
    for (int p = 0; p < 2; p++) begin
      load_imm(5'd1, op_a[p]);
      load_imm(5'd2, op_b[p]);
      for (int k = 0; k < 10; k++) begin
        put_instr(enc_r({1'b0, r_ops[k][3], 5'b0}, 5'd2, 5'd1, r_ops[k][2:0], 5'd3));
        store_check(5'd3, alu_expect(r_ops[k][2:0], r_ops[k][3], op_a[p], op_b[p]));
      end
    end
    // Immediate ops on x1 where srai carries bit 10
    for (int k = 0; k < 9; k++) begin
      put_instr(enc_i(i_imm[k], 5'd1, i_f3[k], 5'd3, 7'b0010011));
      store_check(5'd3, alu_expect(i_f3[k], (i_f3[k] == 3'd5) && i_imm[k][10], op_a[1],
                                   {{20{i_imm[k][11]}}, i_imm[k]}));
    end
    put_instr(enc_u(20'hABCDE, 5'd3, 7'b0110111));
    store_check(5'd3, 32'hABCD_E000);
    pc_at = 32'(prog.size() * 4);
    put_instr(enc_u(20'h00012, 5'd3, 7'b0010111));
    store_check(5'd3, pc_at + 32'h0001_2000);
    // Loads from the seeded words at 0x004..0x00B
    for (int k = 0; k < 4; k++) begin
      load_check(3'd0, 12'(4 + k));
      load_check(3'd4, 12'(4 + k));
    end
    for (int k = 0; k < 4; k += 2) begin
      load_check(3'd1, 12'(8 + k));
      load_check(3'd5, 12'(8 + k));
    end
    load_check(3'd2, 12'd8);
    // Narrow stores at each offset
    load_imm(5'd1, 32'hCAFE_8A7B);
    for (int k = 0; k < 4; k++) begin
      put_instr(enc_s(12'(slot * 4 + k), 5'd1, 5'd31, 3'b000));
      expect_store(STORE_BASE + 32'(slot * 4 + k), 32'h7B << (8 * k), 4'b0001 << k);
      slot++;
    end
    for (int k = 0; k < 4; k += 2) begin
      put_instr(enc_s(12'(slot * 4 + k), 5'd1, 5'd31, 3'b001));
      expect_store(STORE_BASE + 32'(slot * 4 + k), 32'h8A7B << (8 * k), 4'b0011 << k);
      slot++;
    end
    // Branches skip one marker when taken
    for (int p = 0; p < 3; p++) begin
      load_imm(5'd1, br_a[p]);
      load_imm(5'd2, br_b[p]);
      for (int c = 0; c < 6; c++) begin
        put_instr(enc_b(13'd8, 5'd2, 5'd1, br_f3[c]));
        marker_store(branch_expect(br_f3[c], br_a[p], br_b[p]));
      end
    end
    pc_at = 32'(prog.size() * 4);
    put_instr(enc_j(21'd8, 5'd6));
    marker_store(1'b1);
    store_check(5'd6, pc_at + 32'd4);
    // jalr to x7 + 13 lands on pc_at + 12 with bit 0 dropped
    pc_at = 32'(prog.size() * 4);
    put_instr(enc_u(20'h0, 5'd7, 7'b0010111));
    put_instr(enc_i(12'd13, 5'd7, 3'b000, 5'd8, 7'b1100111));
    marker_store(1'b1);
    store_check(5'd8, pc_at + 32'd8);
    put_instr(EBREAK_INSN);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("mismatch %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int   waited;
    logic aborted;
    errors  = 0;
    aborted = 1'b0;
    rst_n   = 1'b0;
    seed    = 32'he1afd82b;
    for (int i = 0; i < 256; i++) begin
      dmem[i]      = $random(seed);
      dmem_init[i] = dmem[i];
    end
    build_program();
    // Unused space traps on ebreak
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : EBREAK_INSN;
    end

    @(posedge clk);
    @(negedge clk);
    check_value("imem_raddr", imem_raddr, 32'h0);
    check_value("dmem_we", {31'b0, dmem_we}, 32'h0);
    @(posedge clk);
    rst_n <= 1'b1;

    // One expected store per loop pass
    for (int i = 0; i < exp_addr.size() && !aborted; i++) begin
      waited = 0;
      @(negedge clk);
      while (dmem_we !== 1'b1 && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (dmem_we !== 1'b1) begin
        $display("Timeout: store %0d of %0d never came", i, exp_addr.size());
        errors++;
        aborted = 1'b1;
      end else begin
        check_value("dmem_waddr", dmem_waddr, exp_addr[i]);
        check_value("dmem_wdata", dmem_wdata, exp_data[i]);
        check_value("dmem_wstrb", {28'h0, dmem_wstrb}, {28'h0, exp_strb[i]});
      end
    end

    if (!aborted) begin
      waited = 0;
      while (ebreak !== 1'b1 && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
        if (dmem_we === 1'b1) begin
          $display("Unexpected store to address %h after the last one", dmem_waddr);
          errors++;
        end
      end
      if (ebreak !== 1'b1) begin
        $display("Timeout: ebreak did not rise after the last store");
        errors++;
      end else begin
        // Halted core stays quiet
        repeat (10) begin
          @(negedge clk);
          check_value("dmem_we", {31'b0, dmem_we}, 32'h0);
          check_value("ebreak", {31'b0, ebreak}, 32'h1);
        end
      end
    end

    if (exp_load.size() != 0) begin
      $display("Missing loads: %0d expected loads never came", exp_load.size());
      errors++;
    end

    $display("Run finished: %0d stores expected, %0d errors", exp_addr.size(), errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* vlog.f */
rv_pkg.sv
rv_ctrl_if.sv
rv_idec.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_pc.sv
rv_core.sv
tb_rv_core.sv
